// File: source/knn_geom_pkg.sv
package knn_geom_pkg;

    // one pixel value
    localparam int DATA_WIDTH = 11;

    // values per patch, index excluded
    localparam int PATCH_SIZE = 5;

    // leaf memories in the bank, and entries per leaf
    localparam int LEAF_SIZE = 8;

    // position of a patch in the source image
    localparam int IDX_WIDTH = 9;

    // default depths: 26 x 19 query patches, 64 leaves
    localparam int NUM_QUERYS_DEF = 494;
    localparam int NUM_LEAVES_DEF = 64;

    // query patch, five packed values
    typedef logic [PATCH_SIZE*DATA_WIDTH-1:0] patch_t;

    // leaf entry, index on top of the patch
    typedef logic [PATCH_SIZE*DATA_WIDTH+IDX_WIDTH-1:0] leaf_word_t;

endpackage

// File: source/wbs_map_pkg.sv
package wbs_map_pkg;

    // bus data and address
    typedef logic [31:0] wb_word_t;
    typedef logic [31:0] wb_addr_t;

    // region decode uses the top byte only
    localparam wb_addr_t WBS_ADDR_MASK  = 32'hFF00_0000;

    // control levels, full address match
    localparam wb_addr_t WBS_MODE_ADDR  = 32'h3000_0000;
    localparam wb_addr_t WBS_DEBUG_ADDR = 32'h3000_0001;

    // memory regions, bit 0 picks the half word
    localparam wb_addr_t WBS_QUERY_ADDR = 32'h3100_0000;
    localparam wb_addr_t WBS_LEAF_ADDR  = 32'h3200_0000;

    // controller states
    typedef enum logic [1:0] {
        idle,
        read_mem,
        reg_mem_read,
        ack
    } wbs_state_t;

endpackage

// File: source/patch_sram.sv
`timescale 1ns/1ps

module patch_sram #(
    parameter int WIDTH = 64,
    parameter int DEPTH = 64
) (
    input  logic                     wb_clk_i,
    input  logic                     cs_n_i,
    input  logic                     we_n_i,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  logic [WIDTH-1:0]         wdata_i,
    output logic [WIDTH-1:0]         rdata_o
);

    logic [WIDTH-1:0] mem [DEPTH];
    logic addr_ok;

    // depth need not be a power of two
    assign addr_ok = addr_i < DEPTH;

    always_ff @(posedge wb_clk_i) begin
        if (!cs_n_i && !we_n_i && addr_ok) begin
            mem[addr_i] <= wdata_i;
        end
    end

    // registered read, out of range reads give 0
    always_ff @(posedge wb_clk_i) begin
        if (!cs_n_i && we_n_i) begin
            if (addr_ok) begin
                rdata_o <= mem[addr_i];
            end else begin
                rdata_o <= '0;
            end
        end
    end

endmodule

// File: source/wbs_ctrl.sv
`timescale 1ns/1ps

module wbs_ctrl #(
    parameter int NUM_QUERYS = knn_geom_pkg::NUM_QUERYS_DEF,
    parameter int NUM_LEAVES = knn_geom_pkg::NUM_LEAVES_DEF
) (
    input  logic                                  wb_clk_i,
    input  logic                                  wb_rst_i,

    input  logic                                  wbs_cyc_i,
    input  logic                                  wbs_stb_i,
    input  logic                                  wbs_we_i,
    // byte selects are not supported, whole words only
    input  logic [3:0]                            wbs_sel_i,
    input  wbs_map_pkg::wb_addr_t                 wbs_adr_i,
    input  wbs_map_pkg::wb_word_t                 wbs_dat_i,
    output logic                                  wbs_ack_o,
    output wbs_map_pkg::wb_word_t                 wbs_dat_o,

    output logic                                  mode_o,
    output logic                                  debug_o,

    output logic                                  qp_cs_n_o,
    output logic                                  qp_we_n_o,
    output logic [$clog2(NUM_QUERYS)-1:0]         qp_addr_o,
    output knn_geom_pkg::patch_t                  qp_wdata_o,
    input  knn_geom_pkg::patch_t                  qp_rdata_i,

    output logic [knn_geom_pkg::LEAF_SIZE-1:0]    leaf_cs_n_o,
    output logic [knn_geom_pkg::LEAF_SIZE-1:0]    leaf_we_n_o,
    output logic [$clog2(NUM_LEAVES)-1:0]         leaf_addr_o,
    output knn_geom_pkg::leaf_word_t              leaf_wdata_o,
    input  knn_geom_pkg::leaf_word_t              leaf_rdata_i [knn_geom_pkg::LEAF_SIZE]
);
    import knn_geom_pkg::*;
    import wbs_map_pkg::*;

    localparam int WB_W    = $bits(wb_word_t);
    localparam int QP_AW   = $clog2(NUM_QUERYS);
    localparam int LEAF_AW = $clog2(NUM_LEAVES);
    localparam int LEAF_SW = $clog2(LEAF_SIZE);
    // query high half is narrower than a bus word
    localparam int QP_HI_W = $bits(patch_t) - WB_W;

    wbs_state_t state_q;
    wbs_state_t state_d;

    logic req_valid;
    logic req_en;
    logic we_q;
    wb_addr_t adr_q;
    wb_word_t dat_q;
    wb_word_t prev_dat_q;

    logic ack_d;
    logic rdata_en;
    wb_word_t rdata_d;
    logic ctrl_wr;

    logic is_query;
    logic is_leaf;
    logic [LEAF_SW-1:0] leaf_sel;
    leaf_word_t full_word;

    assign req_valid = wbs_cyc_i & wbs_stb_i;

    // region decode on the sampled address
    assign is_query = (adr_q & WBS_ADDR_MASK) == WBS_QUERY_ADDR;
    assign is_leaf  = (adr_q & WBS_ADDR_MASK) == WBS_LEAF_ADDR;
    assign leaf_sel = adr_q[LEAF_SW:1];

    // odd half on top, even half from the previous write below
    assign full_word = {dat_q, prev_dat_q};

    assign qp_addr_o    = adr_q[QP_AW:1];
    assign qp_wdata_o   = full_word[$bits(patch_t)-1:0];
    assign leaf_addr_o  = adr_q[LEAF_SW+1 +: LEAF_AW];
    assign leaf_wdata_o = full_word;

    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            state_q <= idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d     = state_q;
        req_en      = 1'b0;
        ack_d       = 1'b0;
        rdata_en    = 1'b0;
        qp_cs_n_o   = 1'b1;
        qp_we_n_o   = 1'b1;
        leaf_cs_n_o = '1;
        leaf_we_n_o = '1;

        case (state_q)
            idle: begin
                if (req_valid) begin
                    req_en = 1'b1;
                    if (wbs_we_i) begin
                        // writes are acked right away, commit follows
                        state_d = ack;
                        ack_d   = 1'b1;
                    end else begin
                        state_d = read_mem;
                    end
                end
            end

            read_mem: begin
                state_d = reg_mem_read;
                if (is_query) begin
                    qp_cs_n_o = 1'b0;
                end else if (is_leaf) begin
                    leaf_cs_n_o[leaf_sel] = 1'b0;
                end
            end

            reg_mem_read: begin
                state_d  = ack;
                ack_d    = 1'b1;
                rdata_en = 1'b1;
            end

            ack: begin
                state_d = idle;
                // only the odd half commits to memory
                if (we_q && adr_q[0]) begin
                    if (is_query) begin
                        qp_cs_n_o = 1'b0;
                        qp_we_n_o = 1'b0;
                    end else if (is_leaf) begin
                        leaf_cs_n_o[leaf_sel] = 1'b0;
                        leaf_we_n_o[leaf_sel] = 1'b0;
                    end
                end
            end

            default: begin
                state_d = idle;
            end
        endcase
    end

    // half word steering, anything unmapped reads 0
    always_comb begin
        rdata_d = '0;
        if (is_query) begin
            if (adr_q[0]) begin
                rdata_d = {{(WB_W-QP_HI_W){1'b0}}, qp_rdata_i[$bits(patch_t)-1:WB_W]};
            end else begin
                rdata_d = qp_rdata_i[WB_W-1:0];
            end
        end else if (is_leaf) begin
            if (adr_q[0]) begin
                rdata_d = leaf_rdata_i[leaf_sel][2*WB_W-1:WB_W];
            end else begin
                rdata_d = leaf_rdata_i[leaf_sel][WB_W-1:0];
            end
        end
    end

    // request sampling
    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            we_q  <= 1'b0;
            adr_q <= '0;
        end else if (req_en) begin
            we_q  <= wbs_we_i;
            adr_q <= wbs_adr_i;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (req_en) begin
            dat_q <= wbs_dat_i;
        end
    end

    assign ctrl_wr = (state_q == ack) && we_q;

    // keeps the last written word for the next odd half
    always_ff @(posedge wb_clk_i) begin
        if (ctrl_wr) begin
            prev_dat_q <= dat_q;
        end
    end

    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            wbs_ack_o <= 1'b0;
            wbs_dat_o <= '0;
        end else begin
            wbs_ack_o <= ack_d;
            if (rdata_en) begin
                wbs_dat_o <= rdata_d;
            end
        end
    end

    // control levels, bit 0 of the data word
    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            mode_o  <= 1'b0;
            debug_o <= 1'b0;
        end else if (ctrl_wr) begin
            if (adr_q == WBS_MODE_ADDR) begin
                mode_o <= dat_q[0];
            end
            if (adr_q == WBS_DEBUG_ADDR) begin
                debug_o <= dat_q[0];
            end
        end
    end

endmodule

// File: source/knn_wb_top.sv
`timescale 1ns/1ps

module knn_wb_top #(
    parameter int NUM_QUERYS = knn_geom_pkg::NUM_QUERYS_DEF,
    parameter int NUM_LEAVES = knn_geom_pkg::NUM_LEAVES_DEF
) (
    input  logic                  wb_clk_i,
    input  logic                  wb_rst_i,
    input  logic                  wbs_cyc_i,
    input  logic                  wbs_stb_i,
    input  logic                  wbs_we_i,
    input  logic [3:0]            wbs_sel_i,
    input  wbs_map_pkg::wb_addr_t wbs_adr_i,
    input  wbs_map_pkg::wb_word_t wbs_dat_i,
    output logic                  wbs_ack_o,
    output wbs_map_pkg::wb_word_t wbs_dat_o,
    output logic                  mode_o,
    output logic                  debug_o
);
    import knn_geom_pkg::*;

    logic                          qp_cs_n;
    logic                          qp_we_n;
    logic [$clog2(NUM_QUERYS)-1:0] qp_addr;
    patch_t                        qp_wdata;
    patch_t                        qp_rdata;

    logic [LEAF_SIZE-1:0]          leaf_cs_n;
    logic [LEAF_SIZE-1:0]          leaf_we_n;
    logic [$clog2(NUM_LEAVES)-1:0] leaf_addr;
    leaf_word_t                    leaf_wdata;
    leaf_word_t                    leaf_rdata [LEAF_SIZE];

    wbs_ctrl #(
        .NUM_QUERYS (NUM_QUERYS),
        .NUM_LEAVES (NUM_LEAVES)
    ) ctrl_i (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .wbs_cyc_i    (wbs_cyc_i),
        .wbs_stb_i    (wbs_stb_i),
        .wbs_we_i     (wbs_we_i),
        .wbs_sel_i    (wbs_sel_i),
        .wbs_adr_i    (wbs_adr_i),
        .wbs_dat_i    (wbs_dat_i),
        .wbs_ack_o    (wbs_ack_o),
        .wbs_dat_o    (wbs_dat_o),
        .mode_o       (mode_o),
        .debug_o      (debug_o),
        .qp_cs_n_o    (qp_cs_n),
        .qp_we_n_o    (qp_we_n),
        .qp_addr_o    (qp_addr),
        .qp_wdata_o   (qp_wdata),
        .qp_rdata_i   (qp_rdata),
        .leaf_cs_n_o  (leaf_cs_n),
        .leaf_we_n_o  (leaf_we_n),
        .leaf_addr_o  (leaf_addr),
        .leaf_wdata_o (leaf_wdata),
        .leaf_rdata_i (leaf_rdata)
    );

    patch_sram #(
        .WIDTH ($bits(patch_t)),
        .DEPTH (NUM_QUERYS)
    ) qp_mem_i (
        .wb_clk_i (wb_clk_i),
        .cs_n_i   (qp_cs_n),
        .we_n_i   (qp_we_n),
        .addr_i   (qp_addr),
        .wdata_i  (qp_wdata),
        .rdata_o  (qp_rdata)
    );

    // one memory per entry slot, shared address and write data
    for (genvar i = 0; i < LEAF_SIZE; i++) begin : leaf_mem_g
        patch_sram #(
            .WIDTH ($bits(leaf_word_t)),
            .DEPTH (NUM_LEAVES)
        ) mem_i (
            .wb_clk_i (wb_clk_i),
            .cs_n_i   (leaf_cs_n[i]),
            .we_n_i   (leaf_we_n[i]),
            .addr_i   (leaf_addr),
            .wdata_i  (leaf_wdata),
            .rdata_o  (leaf_rdata[i])
        );
    end

endmodule

// File: tests/knn_wb_sva.sv
`timescale 1ns/1ps

module knn_wb_sva (
    input logic                                wb_clk_i,
    input logic                                wb_rst_i,
    input logic                                cyc_i,
    input logic                                stb_i,
    input logic                                we_i,
    input logic                                ack_i,
    input wbs_map_pkg::wbs_state_t             state_i,
    input logic                                qp_we_n_i,
    input logic [knn_geom_pkg::LEAF_SIZE-1:0]  leaf_cs_n_i,
    input logic [knn_geom_pkg::LEAF_SIZE-1:0]  leaf_we_n_i
);
    import wbs_map_pkg::*;

    logic req_wr;
    logic req_rd;

    // requests are taken in idle only
    assign req_wr = (state_i == idle) && cyc_i && stb_i && we_i;
    assign req_rd = (state_i == idle) && cyc_i && stb_i && !we_i;

    ack_pulse_a: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        ack_i |=> !ack_i)
        else $error("ack held for more than one cycle");

    write_ack_a: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        $past(req_wr) |-> ack_i)
        else $error("write not acked one cycle after sampling");

    read_early_a: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        req_rd |=> !ack_i)
        else $error("read acked too early");

    read_ack_a: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        $past(req_rd, 3) |-> ack_i)
        else $error("read not acked three cycles after sampling");

    strobe_a: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        (!qp_we_n_i || !(&leaf_we_n_i)) |-> $past(req_wr))
        else $error("memory write strobe without a sampled write");

    // a leaf select follows a sampled request, one leaf at a time
    leaf_sel_a: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        !(&leaf_cs_n_i) |-> $onehot(~leaf_cs_n_i) && $past(req_wr || req_rd))
        else $error("leaf memory selected without a request or more than one selected");

endmodule

// File: tests/knn_wb_tb.sv
`timescale 1ns/1ps

module knn_wb_tb;
    import knn_geom_pkg::*;
    import wbs_map_pkg::*;

    localparam int ACK_TIMEOUT = 20;

    logic       wb_clk_i;
    logic       wb_rst_i;
    logic       wbs_cyc_i;
    logic       wbs_stb_i;
    logic       wbs_we_i;
    logic [3:0] wbs_sel_i;
    wb_addr_t   wbs_adr_i;
    wb_word_t   wbs_dat_i;
    logic       wbs_ack_o;
    wb_word_t   wbs_dat_o;
    logic       mode_o;
    logic       debug_o;

    integer seed;
    int errors;
    int checks;
    int tests;
    int test_errors;
    string cur_test;

    // both bus words of an entry, low word first
    logic [63:0] qp_model [int];
    logic [63:0] leaf_model [int];
    wb_word_t last_wdata;
    wb_addr_t written_q [$];
    wb_word_t exp_q [$];
    string name_q [$];

    knn_wb_top #(
        .NUM_QUERYS (NUM_QUERYS_DEF),
        .NUM_LEAVES (NUM_LEAVES_DEF)
    ) knn_wb_top_i (
        .wb_clk_i  (wb_clk_i),
        .wb_rst_i  (wb_rst_i),
        .wbs_cyc_i (wbs_cyc_i),
        .wbs_stb_i (wbs_stb_i),
        .wbs_we_i  (wbs_we_i),
        .wbs_sel_i (wbs_sel_i),
        .wbs_adr_i (wbs_adr_i),
        .wbs_dat_i (wbs_dat_i),
        .wbs_ack_o (wbs_ack_o),
        .wbs_dat_o (wbs_dat_o),
        .mode_o    (mode_o),
        .debug_o   (debug_o)
    );

    bind wbs_ctrl knn_wb_sva sva_i (
        .wb_clk_i    (wb_clk_i),
        .wb_rst_i    (wb_rst_i),
        .cyc_i       (wbs_cyc_i),
        .stb_i       (wbs_stb_i),
        .we_i        (wbs_we_i),
        .ack_i       (wbs_ack_o),
        .state_i     (state_q),
        .qp_we_n_i   (qp_we_n_o),
        .leaf_cs_n_i (leaf_cs_n_o),
        .leaf_we_n_i (leaf_we_n_o)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #4 wb_clk_i = ~wb_clk_i;
    end

    function automatic int rand_below(int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    function automatic wb_addr_t query_addr(int idx);
        return WBS_QUERY_ADDR | (wb_addr_t'(idx) << 1);
    endfunction

    function automatic wb_addr_t leaf_addr(int sel, int entry);
        return WBS_LEAF_ADDR | (wb_addr_t'(entry) << 4) | (wb_addr_t'(sel) << 1);
    endfunction

    // expected read word from the address map and the memory models
    function automatic wb_word_t expected_word(wb_addr_t a);
        int key;
        logic [63:0] entry;
        key = int'(a[9:1]);
        entry = '0;
        if ((a & WBS_ADDR_MASK) == WBS_QUERY_ADDR) begin
            if (qp_model.exists(key)) begin
                entry = qp_model[key];
            end
            // query high word carries only 23 bits
            entry = entry & 64'h007F_FFFF_FFFF_FFFF;
        end else if ((a & WBS_ADDR_MASK) == WBS_LEAF_ADDR) begin
            if (leaf_model.exists(key)) begin
                entry = leaf_model[key];
            end
        end
        return a[0] ? entry[63:32] : entry[31:0];
    endfunction

    // odd half commits itself on top of the previous write
    function automatic void model_write(wb_addr_t a, wb_word_t d);
        int key;
        key = int'(a[9:1]);
        if (a[0]) begin
            if ((a & WBS_ADDR_MASK) == WBS_QUERY_ADDR) begin
                qp_model[key] = {d, last_wdata};
            end else if ((a & WBS_ADDR_MASK) == WBS_LEAF_ADDR) begin
                leaf_model[key] = {d, last_wdata};
            end
        end
        last_wdata = d;
    endfunction

    task automatic check_word(input string name, input wb_word_t exp, input wb_word_t act);
        checks++;
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_levels(input string what, input logic mode_exp, input logic debug_exp);
        check_level({cur_test, " mode ", what}, mode_exp, mode_o);
        check_level({cur_test, " debug ", what}, debug_exp, debug_o);
    endtask

    task automatic finish_run();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic abort_run(input string msg);
        $display("error: %s", msg);
        errors++;
        finish_run();
    endtask

    task automatic test_begin(input string name);
        cur_test = name;
        test_errors = errors;
    endtask

    task automatic test_end();
        tests++;
        $display("%s: %s, %0d errors", cur_test,
                 (errors == test_errors) ? "ok" : "failed", errors - test_errors);
    endtask

    task automatic wait_ack(output logic seen);
        int cycles;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < ACK_TIMEOUT) begin
            @(negedge wb_clk_i);
            cycles++;
            seen = wbs_ack_o;
        end
    endtask

    task automatic wb_write(input wb_addr_t addr, input wb_word_t data);
        logic seen;
        @(negedge wb_clk_i);
        wbs_cyc_i <= 1'b1;
        wbs_stb_i <= 1'b1;
        wbs_we_i  <= 1'b1;
        wbs_adr_i <= addr;
        wbs_dat_i <= data;
        wait_ack(seen);
        if (!seen) begin
            abort_run($sformatf("no ack came back for the write to %h", addr));
        end else begin
            wbs_cyc_i <= 1'b0;
            wbs_stb_i <= 1'b0;
            wbs_we_i  <= 1'b0;
            model_write(addr, data);
            @(negedge wb_clk_i);
        end
    endtask

    task automatic wb_read(input wb_addr_t addr);
        logic seen;
        exp_q.push_back(expected_word(addr));
        name_q.push_back($sformatf("%s read %h", cur_test, addr));
        @(negedge wb_clk_i);
        wbs_cyc_i <= 1'b1;
        wbs_stb_i <= 1'b1;
        wbs_we_i  <= 1'b0;
        wbs_adr_i <= addr;
        wait_ack(seen);
        if (!seen) begin
            abort_run($sformatf("no ack came back for the read of %h", addr));
        end else begin
            wbs_cyc_i <= 1'b0;
            wbs_stb_i <= 1'b0;
            @(negedge wb_clk_i);
        end
    endtask

    task automatic write_pair(input wb_addr_t base, input wb_word_t lo, input wb_word_t hi);
        wb_write(base, lo);
        wb_write(base | 32'h1, hi);
    endtask

    task automatic read_pair(input wb_addr_t base);
        wb_read(base);
        wb_read(base | 32'h1);
    endtask

    // read data is compared on the falling edge that sees ack
    initial begin
        forever begin
            @(negedge wb_clk_i);
            if (wbs_ack_o && wbs_cyc_i && !wbs_we_i) begin
                if (exp_q.size() == 0) begin
                    $display("error: a read was acknowledged with no read outstanding");
                    errors++;
                end else begin
                    check_word(name_q.pop_front(), exp_q.pop_front(), wbs_dat_o);
                end
            end
        end
    end

    initial begin
        wb_addr_t base;
        seed = 32'h068365ad;
        wb_rst_i  <= 1'b1;
        wbs_cyc_i <= 1'b0;
        wbs_stb_i <= 1'b0;
        wbs_we_i  <= 1'b0;
        wbs_sel_i <= 4'hF;
        wbs_adr_i <= '0;
        wbs_dat_i <= '0;
        repeat (5) @(posedge wb_clk_i);
        @(negedge wb_clk_i);
        wb_rst_i <= 1'b0;
        @(negedge wb_clk_i);

        test_begin("control levels");
        check_level({cur_test, " ack after reset"}, 1'b0, wbs_ack_o);
        check_levels("after reset", 1'b0, 1'b0);
        wb_write(WBS_MODE_ADDR, 32'h1);
        check_levels("mode set", 1'b1, 1'b0);
        wb_write(WBS_MODE_ADDR, 32'h0);
        check_levels("mode clear", 1'b0, 1'b0);
        wb_write(WBS_DEBUG_ADDR, 32'h1);
        check_levels("debug set", 1'b0, 1'b1);
        wb_write(WBS_DEBUG_ADDR, 32'h0);
        check_levels("debug clear", 1'b0, 1'b0);
        test_end();

        test_begin("query pairs");
        for (int n = 0; n < 5; n++) begin
            write_pair(query_addr(n * 123 + 1), $random(seed), $random(seed));
        end
        for (int n = 0; n < 5; n++) begin
            read_pair(query_addr(n * 123 + 1));
        end
        test_end();

        test_begin("leaf entries");
        for (int s = 0; s < LEAF_SIZE; s++) begin
            write_pair(leaf_addr(s, 3 + 7 * s), $random(seed), $random(seed));
            // same entry in every leaf exposes a write that reaches the wrong leaf
            write_pair(leaf_addr(s, 60), $random(seed), $random(seed));
        end
        for (int s = 0; s < LEAF_SIZE; s++) begin
            read_pair(leaf_addr(s, 3 + 7 * s));
            read_pair(leaf_addr(s, 60));
        end
        test_end();

        test_begin("random traffic");
        for (int n = 0; n < 40; n++) begin
            if (rand_below(2) == 0) begin
                base = query_addr(rand_below(NUM_QUERYS_DEF));
            end else begin
                base = leaf_addr(rand_below(LEAF_SIZE), rand_below(NUM_LEAVES_DEF));
            end
            write_pair(base, $random(seed), $random(seed));
            written_q.push_back(base);
            read_pair(written_q[rand_below(written_q.size())]);
        end
        test_end();

        test_begin("unmapped reads");
        wb_write(WBS_MODE_ADDR, 32'h1);
        wb_write(WBS_DEBUG_ADDR, 32'h1);
        wb_read(WBS_MODE_ADDR);
        wb_read(WBS_DEBUG_ADDR);
        wb_read(32'h3300_0000);
        wb_read(32'h0000_0006);
        wb_read(32'h3000_0002);
        wb_write(WBS_MODE_ADDR, 32'h0);
        wb_write(WBS_DEBUG_ADDR, 32'h0);
        test_end();

        test_begin("lone even half");
        base = query_addr(37);
        write_pair(base, 32'h1234_5678, 32'hFFD5_AA33);
        wb_write(base, 32'hDEAD_BEEF);
        read_pair(base);
        base = leaf_addr(2, 40);
        write_pair(base, 32'h0BAD_F00D, 32'h7654_3210);
        wb_write(base, 32'hCAFE_0001);
        read_pair(base);
        test_end();

        if (exp_q.size() != 0) begin
            $display("error: %0d reads were never acknowledged", exp_q.size());
            errors++;
        end
        finish_run();
    end

endmodule

// File: sources.f
source/knn_geom_pkg.sv
source/wbs_map_pkg.sv
source/patch_sram.sv
source/wbs_ctrl.sv
source/knn_wb_top.sv
tests/knn_wb_sva.sv
tests/knn_wb_tb.sv

// File: Makefile
TOP := knn_wb_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "TEST RESULT: PASS" sim.log || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf obj_dir sim.log
